/* filelist.f */
src/isa_pkg.sv
src/core_pkg.sv
src/reg_file.sv
src/fetch_unit.sv
src/decoder.sv
src/alu.sv
src/mem_unit.sv
src/cpu.sv
testbench/tb_mem_model.sv
testbench/tb_cpu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_cpu -f filelist.f \
    -Mdir obj_dir -o sim_cpu

./obj_dir/sim_cpu > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

/* src/alu.sv */
`default_nettype none

module alu
    import isa_pkg::*;
(
    input  wire funct3_t funct3,
    input  wire          alt,
    input  wire          use_imm,
    input  wire word_t   a,
    input  wire word_t   b,
    input  wire word_t   imm,
    output word_t        result,
    output logic         taken
);

    word_t      op2;
    logic [4:0] shamt;

    assign op2   = use_imm ? imm : b;
    assign shamt = op2[4:0];

    always_comb begin
        case (funct3)
            // bit 30 of an addi is part of its immediate
            f3_add:  result = (alt && !use_imm) ? a - op2 : a + op2;
            f3_sll:  result = a << shamt;
            f3_slt:  result = word_t'($signed(a) < $signed(op2));
            f3_sltu: result = word_t'(a < op2);
            f3_xor:  result = a ^ op2;
            f3_srl: begin
                // sra keeps the sign bit
                if (alt) begin
                    result = $signed(a) >>> shamt;
                end else begin
                    result = a >> shamt;
                end
            end
            f3_or:   result = a | op2;
            f3_and:  result = a & op2;
            default: result = a + op2;
        endcase
    end

    // branch condition always on the two register values
    always_comb begin
        case (funct3)
            f3_beq:  taken = (a == b);
            f3_bne:  taken = (a != b);
            f3_blt:  taken = ($signed(a) < $signed(b));
            f3_bge:  taken = ($signed(a) >= $signed(b));
            f3_bltu: taken = (a < b);
            f3_bgeu: taken = (a >= b);
            default: taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

    import isa_pkg::*;

    typedef logic [11:0] inst_addr_t;
    typedef logic [13:0] data_addr_t;

    localparam int len_strobe = 4;

    typedef logic [len_strobe-1:0] strobe_t;

    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_execute,
        st_execute_wait,
        st_write
    } ctrl_state_t;

    typedef enum logic [2:0] {
        cls_alu,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_lui
    } op_class_t;

    // registered at the end of decode
    typedef struct packed {
        op_class_t  op_class;
        funct3_t    funct3;
        logic       alt;
        logic       use_imm;
        word_t      rs1;
        word_t      rs2;
        word_t      imm;
        reg_addr_t  rd;
        inst_addr_t target;
    } decoded_t;

    typedef struct packed {
        logic       write_en;
        reg_addr_t  rd;
        word_t      value;
        inst_addr_t next_pc;
    } exec_result_t;

endpackage

`default_nettype wire

/* src/cpu.sv */
`default_nettype none

module cpu
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire             clk,
    input  wire             rstn,
    output logic            inst_req,
    output inst_addr_t      inst_addr,
    input  wire             inst_ack,
    input  wire word_t      inst_data,
    output logic            data_req,
    output logic            data_we,
    output strobe_t         data_strobe,
    output data_addr_t      data_addr,
    output word_t           data_wdata,
    input  wire             data_ack,
    input  wire word_t      data_rdata
);

    ctrl_state_t  state;
    inst_addr_t   pc;
    inst_addr_t   pc_seq;
    decoded_t     dec_c;
    decoded_t     dec_q;
    exec_result_t res;

    logic      fetch_start;
    logic      fetch_done;
    word_t     inst_word;
    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;
    word_t     alu_result;
    logic      alu_taken;
    logic      is_mem;
    logic      mem_start;
    logic      mem_done;
    word_t     mem_rdata;
    logic      rf_we;

    assign pc_seq      = pc + 12'd4;
    assign is_mem      = (dec_q.op_class == cls_load) || (dec_q.op_class == cls_store);
    assign fetch_start = (state == st_fetch);
    assign mem_start   = (state == st_execute) && is_mem;
    assign rf_we       = (state == st_write) && res.write_en;

    reg_file i_reg_file (
        .clk(clk), .rstn(rstn), .we(rf_we), .wa(res.rd), .wd(res.value),
        .ra1(ra1), .ra2(ra2), .rd1(rd1), .rd2(rd2)
    );

    fetch_unit i_fetch_unit (
        .clk(clk), .rstn(rstn), .start(fetch_start), .pc(pc),
        .done(fetch_done), .inst(inst_word),
        .inst_req(inst_req), .inst_addr(inst_addr),
        .inst_ack(inst_ack), .inst_data(inst_data)
    );

    decoder i_decoder (
        .inst(inst_word), .pc(pc), .ra1(ra1), .ra2(ra2),
        .rd1(rd1), .rd2(rd2), .dec(dec_c)
    );

    alu i_alu (
        .funct3(dec_q.funct3), .alt(dec_q.alt), .use_imm(dec_q.use_imm),
        .a(dec_q.rs1), .b(dec_q.rs2), .imm(dec_q.imm),
        .result(alu_result), .taken(alu_taken)
    );

    mem_unit i_mem_unit (
        .clk(clk), .rstn(rstn), .start(mem_start),
        .store(dec_q.op_class == cls_store), .funct3(dec_q.funct3),
        .base(dec_q.rs1), .offset(dec_q.imm), .wdata(dec_q.rs2),
        .done(mem_done), .rdata(mem_rdata),
        .data_req(data_req), .data_we(data_we), .data_strobe(data_strobe),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .data_ack(data_ack), .data_rdata(data_rdata)
    );

    // result of the instruction, stable from execute through write
    always_comb begin
        res.write_en = 1'b0;
        res.rd       = dec_q.rd;
        res.value    = alu_result;
        res.next_pc  = pc_seq;
        case (dec_q.op_class)
            cls_alu: begin
                res.write_en = 1'b1;
            end
            cls_lui: begin
                res.write_en = 1'b1;
                res.value    = dec_q.imm;
            end
            cls_load: begin
                res.write_en = 1'b1;
                res.value    = mem_rdata;
            end
            cls_branch: begin
                if (alu_taken) begin
                    res.next_pc = dec_q.target;
                end
            end
            cls_jal, cls_jalr: begin
                res.write_en = 1'b1;
                res.value    = word_t'(pc_seq);
                res.next_pc  = dec_q.target;
            end
            default: begin
                res.write_en = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= st_fetch;
            pc    <= '0;
        end else begin
            case (state)
                st_fetch: begin
                    state <= st_fetch_wait;
                end
                st_fetch_wait: begin
                    if (fetch_done) begin
                        state <= st_decode;
                    end
                end
                st_decode: begin
                    state <= st_execute;
                end
                st_execute: begin
                    state <= is_mem ? st_execute_wait : st_write;
                end
                st_execute_wait: begin
                    if (mem_done) begin
                        state <= st_write;
                    end
                end
                st_write: begin
                    // word-aligned fetch address
                    pc    <= {res.next_pc[11:2], 2'b00};
                    state <= st_fetch;
                end
                default: begin
                    state <= st_fetch;
                end
            endcase
        end
    end

    // operands captured while the register file is stable
    always_ff @(posedge clk) begin
        if (state == st_decode) begin
            dec_q <= dec_c;
        end
    end

endmodule

`default_nettype wire

/* src/decoder.sv */
`default_nettype none

module decoder
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire word_t      inst,
    input  wire inst_addr_t pc,
    output reg_addr_t       ra1,
    output reg_addr_t       ra2,
    input  wire word_t      rd1,
    input  wire word_t      rd2,
    output decoded_t        dec
);

    opcode_t opcode;
    word_t   imm_i;
    word_t   imm_s;
    word_t   imm_b;
    word_t   imm_j;
    word_t   imm_u;

    assign opcode = inst[6:0];
    assign ra1    = inst[19:15];
    assign ra2    = inst[24:20];

    // sign-extended immediates of each format
    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        dec.op_class = cls_alu;
        dec.funct3   = inst[14:12];
        dec.alt      = inst[30];
        dec.use_imm  = 1'b0;
        dec.rs1      = rd1;
        dec.rs2      = rd2;
        dec.imm      = imm_i;
        dec.rd       = inst[11:7];
        dec.target   = pc + imm_b[11:0];

        case (opcode)
            op_alu_reg: begin
                dec.op_class = cls_alu;
            end
            op_alu_imm: begin
                dec.op_class = cls_alu;
                dec.use_imm  = 1'b1;
            end
            op_load: begin
                dec.op_class = cls_load;
            end
            op_store: begin
                dec.op_class = cls_store;
                dec.imm      = imm_s;
            end
            op_branch: begin
                dec.op_class = cls_branch;
                dec.imm      = imm_b;
            end
            op_jal: begin
                dec.op_class = cls_jal;
                dec.imm      = imm_j;
                dec.target   = pc + imm_j[11:0];
            end
            op_jalr: begin
                dec.op_class = cls_jalr;
                dec.target   = rd1[11:0] + imm_i[11:0];
            end
            op_lui: begin
                dec.op_class = cls_lui;
                dec.imm      = imm_u;
            end
            default: begin
                // unknown opcode runs as an add into x0
                dec.rd = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* src/fetch_unit.sv */
`default_nettype none

module fetch_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire             clk,
    input  wire             rstn,
    input  wire             start,
    input  wire inst_addr_t pc,
    output logic            done,
    output word_t           inst,
    output logic            inst_req,
    output inst_addr_t      inst_addr,
    input  wire             inst_ack,
    input  wire word_t      inst_data
);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            inst_req <= 1'b0;
        end else if (start) begin
            inst_req <= 1'b1;
        end else if (inst_ack) begin
            inst_req <= 1'b0;
        end
    end

    // address and returned word
    always_ff @(posedge clk) begin
        if (start) begin
            inst_addr <= pc;
        end
        if (inst_req && inst_ack) begin
            inst <= inst_data;
        end
    end

    // request drops right after the ack, so this is a single cycle
    assign done = inst_req && inst_ack;

endmodule

`default_nettype wire

/* src/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;

    // major opcodes of the kept subset
    localparam opcode_t op_alu_reg = 7'b0110011;
    localparam opcode_t op_alu_imm = 7'b0010011;
    localparam opcode_t op_load    = 7'b0000011;
    localparam opcode_t op_store   = 7'b0100011;
    localparam opcode_t op_branch  = 7'b1100011;
    localparam opcode_t op_jal     = 7'b1101111;
    localparam opcode_t op_jalr    = 7'b1100111;
    localparam opcode_t op_lui     = 7'b0110111;

    // alu operations, sub and sra share codes with add and srl
    localparam funct3_t f3_add  = 3'b000;
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_srl  = 3'b101;
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;

    // branch conditions
    localparam funct3_t f3_beq  = 3'b000;
    localparam funct3_t f3_bne  = 3'b001;
    localparam funct3_t f3_blt  = 3'b100;
    localparam funct3_t f3_bge  = 3'b101;
    localparam funct3_t f3_bltu = 3'b110;
    localparam funct3_t f3_bgeu = 3'b111;

    // load and store sizes
    localparam funct3_t f3_byte = 3'b000;
    localparam funct3_t f3_word = 3'b010;

endpackage

`default_nettype wire

/* src/mem_unit.sv */
`default_nettype none

module mem_unit
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire          clk,
    input  wire          rstn,
    input  wire          start,
    input  wire          store,
    input  wire funct3_t funct3,
    input  wire word_t   base,
    input  wire word_t   offset,
    input  wire word_t   wdata,
    output logic         done,
    output word_t        rdata,
    output logic         data_req,
    output logic         data_we,
    output strobe_t      data_strobe,
    output data_addr_t   data_addr,
    output word_t        data_wdata,
    input  wire          data_ack,
    input  wire word_t   data_rdata
);

    data_addr_t addr;
    strobe_t    strobe;
    word_t      wdata_lane;

    assign addr = data_addr_t'(base + offset);

    // sb puts the byte on every lane and enables one of them
    always_comb begin
        case (funct3)
            f3_byte: begin
                strobe     = strobe_t'(1) << addr[1:0];
                wdata_lane = {4{wdata[7:0]}};
            end
            f3_word: begin
                strobe     = '1;
                wdata_lane = wdata;
            end
            default: begin
                strobe     = '1;
                wdata_lane = wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            data_req <= 1'b0;
            data_we  <= 1'b0;
        end else if (start) begin
            data_req <= 1'b1;
            data_we  <= store;
        end else if (data_ack) begin
            data_req <= 1'b0;
            data_we  <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            data_addr   <= addr;
            data_strobe <= store ? strobe : '1;
            data_wdata  <= wdata_lane;
        end
        if (data_req && data_ack && !data_we) begin
            rdata <= data_rdata;
        end
    end

    assign done = data_req && data_ack;

endmodule

`default_nettype wire

/* src/reg_file.sv */
`default_nettype none

module reg_file
    import isa_pkg::*;
(
    input  wire       clk,
    input  wire       rstn,
    input  wire       we,
    input  wire       reg_addr_t wa,
    input  wire       word_t wd,
    input  wire       reg_addr_t ra1,
    input  wire       reg_addr_t ra2,
    output word_t     rd1,
    output word_t     rd2
);

    // x0 has no storage
    word_t regs [31:1];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

/* testbench/tb_cpu.sv */
`default_nettype none

module tb_cpu
    import isa_pkg::*;
    import core_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // about 160 instructions run in all, rounded up
    localparam int total_insts = 200;
    localparam int max_cycles  = 12 * total_insts;

    logic       clk;
    logic       rstn;
    logic       inst_req;
    inst_addr_t inst_addr;
    logic       inst_ack;
    word_t      inst_data;
    logic       data_req;
    logic       data_we;
    strobe_t    data_strobe;
    data_addr_t data_addr;
    word_t      data_wdata;
    logic       data_ack;
    word_t      data_rdata;
    logic [1:0] inst_delay;
    logic [1:0] data_delay;

    logic        random_delays;
    logic [31:0] rng;
    int          errors;
    int          cycles;
    int          wp;
    logic        sentinel_seen;

    data_addr_t got_addr [$];
    word_t      got_data [$];
    strobe_t    got_strb [$];
    data_addr_t exp_addr [$];
    word_t      exp_data [$];
    strobe_t    exp_strb [$];
    data_addr_t sv_addr [$];
    word_t      sv_data [$];
    strobe_t    sv_strb [$];

    cpu i_cpu (
        .clk(clk), .rstn(rstn),
        .inst_req(inst_req), .inst_addr(inst_addr), .inst_ack(inst_ack), .inst_data(inst_data),
        .data_req(data_req), .data_we(data_we), .data_strobe(data_strobe),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .data_ack(data_ack), .data_rdata(data_rdata)
    );

    tb_mem_model i_mem (
        .clk(clk), .rstn(rstn),
        .inst_req(inst_req), .inst_addr(inst_addr), .inst_ack(inst_ack), .inst_data(inst_data),
        .data_req(data_req), .data_we(data_we), .data_strobe(data_strobe),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .data_ack(data_ack), .data_rdata(data_rdata),
        .inst_delay(inst_delay), .data_delay(data_delay)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    always @(negedge clk) begin
        if (random_delays) begin
            rng        = xorshift(rng);
            inst_delay = rng[1:0];
            data_delay = rng[9:8];
        end else begin
            inst_delay = 2'd0;
            data_delay = 2'd0;
        end
    end

    // record every store, the sentinel only ends the run
    always @(posedge clk) begin
        if (rstn && data_req && data_ack && data_we) begin
            if (data_addr == 14'h3FFC) begin
                sentinel_seen = 1'b1;
            end else begin
                got_addr.push_back(data_addr);
                got_data.push_back(data_wdata);
                got_strb.push_back(data_strobe);
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout: the core did not reach the end of its program in %0d cycles",
                max_cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // instruction formats
    function automatic word_t enc_r(funct3_t f3, logic alt, reg_addr_t rd, reg_addr_t rs1,
                                    reg_addr_t rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, op_alu_reg};
    endfunction

    function automatic word_t enc_i(opcode_t op, funct3_t f3, reg_addr_t rd, reg_addr_t rs1,
                                    logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2,
                                    logic [11:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2,
                                    logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t enc_j(reg_addr_t rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    task automatic emit(input word_t w);
        i_mem.imem[wp >> 2] = w;
        wp = wp + 4;
    endtask

    task automatic expect_store(input data_addr_t a, input word_t d, input strobe_t s);
        exp_addr.push_back(a);
        exp_data.push_back(d);
        exp_strb.push_back(s);
    endtask

    task automatic clear_expected();
        exp_addr.delete();
        exp_data.delete();
        exp_strb.delete();
    endtask

    // holds the core in reset while memories and program are set up
    task automatic begin_program();
        @(negedge clk);
        rstn = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            i_mem.imem[i] = 32'h0000_0013;
        end
        for (int i = 0; i < 4096; i++) begin
            i_mem.dmem[i] = {i[15:0], ~i[15:0]};
        end
        got_addr.delete();
        got_data.delete();
        got_strb.delete();
        sentinel_seen = 1'b0;
        wp = 0;
    endtask

    task automatic run_program();
        repeat (5) @(negedge clk);
        rstn = 1'b1;
        check("inst_req after reset", word_t'(inst_req), 32'd0);
        check("data_req after reset", word_t'(data_req), 32'd0);
        check("data_we after reset", word_t'(data_we), 32'd0);
        while (!inst_req) @(negedge clk);
        check("first inst_addr", word_t'(inst_addr), 32'd0);
        check("data_req at first fetch", word_t'(data_req), 32'd0);
        while (!sentinel_seen) @(negedge clk);
    endtask

    task automatic compare_stores(input string name);
        check({name, " store count"}, got_addr.size(), exp_addr.size());
        for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
            check($sformatf("%s store %0d addr", name, i), got_addr[i], exp_addr[i]);
            check($sformatf("%s store %0d data", name, i), got_data[i], exp_data[i]);
            check($sformatf("%s store %0d strobe", name, i), got_strb[i], exp_strb[i]);
        end
    endtask

    task automatic load_alu_program();
        funct3_t f3s [10];
        logic    alts [10];
        word_t   exp_vals [10];
        f3s  = '{f3_add, f3_add, f3_sll, f3_slt, f3_sltu, f3_xor, f3_srl, f3_srl, f3_or, f3_and};
        alts = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
        // x1 = 0xF0000123 and x2 = 5 through each operation
        exp_vals = '{32'hF000_0128, 32'hF000_011E, 32'h0000_2460, 32'h0000_0001,
                     32'h0000_0000, 32'hF000_0126, 32'h0780_0009, 32'hFF80_0009,
                     32'hF000_0127, 32'h0000_0001};
        emit({20'hF0000, 5'd1, op_lui});
        emit(enc_i(op_alu_imm, f3_add, 1, 1, 12'h123));
        emit(enc_i(op_alu_imm, f3_add, 2, 0, 12'd5));
        for (int k = 0; k < 10; k++) begin
            emit(enc_r(f3s[k], alts[k], 3, 1, 2));
            emit(enc_s(f3_word, 0, 3, 12'h100 + 12'(4 * k)));
            expect_store(14'h100 + 14'(4 * k), exp_vals[k], 4'hF);
        end
        // addi with a negative immediate
        emit(enc_i(op_alu_imm, f3_add, 4, 1, 12'hFFF));
        emit(enc_s(f3_word, 0, 4, 12'h140));
        expect_store(14'h140, 32'hF000_0122, 4'hF);
        emit(enc_s(f3_word, 0, 0, 12'hFFC));
    endtask

    task automatic test_alu();
        clear_expected();
        begin_program();
        load_alu_program();
        run_program();
        compare_stores("alu");
    endtask

    task automatic test_load_store();
        clear_expected();
        begin_program();
        emit({20'h12345, 5'd1, op_lui});
        emit(enc_i(op_alu_imm, f3_add, 1, 1, 12'h678));
        emit(enc_s(f3_word, 0, 1, 12'h200));
        emit(enc_i(op_load, f3_word, 2, 0, 12'h200));
        emit(enc_s(f3_word, 0, 2, 12'h204));
        emit(enc_i(op_alu_imm, f3_add, 3, 0, 12'h0AB));
        emit(enc_s(f3_byte, 0, 3, 12'h205));
        emit(enc_s(f3_word, 0, 0, 12'hFFC));
        expect_store(14'h200, 32'h1234_5678, 4'hF);
        expect_store(14'h204, 32'h1234_5678, 4'hF);
        expect_store(14'h205, 32'hABAB_ABAB, 4'b0010);
        run_program();
        compare_stores("load/store");
        check("merged word", i_mem.dmem[14'h204 >> 2], 32'h1234_AB78);
    endtask

    task automatic test_branches();
        funct3_t    f3s [6];
        logic [2:0] taken_map [6];
        reg_addr_t  ra;
        reg_addr_t  rb;
        int         idx;
        f3s = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
        // bit p set when pair p branches, with x1 = -1 and x2 = 1
        taken_map = '{3'b100, 3'b011, 3'b001, 3'b110, 3'b010, 3'b101};
        clear_expected();
        begin_program();
        emit(enc_i(op_alu_imm, f3_add, 1, 0, 12'hFFF));
        emit(enc_i(op_alu_imm, f3_add, 2, 0, 12'd1));
        idx = 0;
        for (int f = 0; f < 6; f++) begin
            // operand pairs (x1,x2) (x2,x1) (x1,x1)
            for (int p = 0; p < 3; p++) begin
                ra = (p == 1) ? 5'd2 : 5'd1;
                rb = (p == 0) ? 5'd2 : 5'd1;
                emit(enc_b(f3s[f], ra, rb, 13'd12));
                emit(enc_i(op_alu_imm, f3_add, 5, 0, 12'h200 + 12'(idx)));
                emit(enc_j(0, 21'd8));
                emit(enc_i(op_alu_imm, f3_add, 5, 0, 12'h100 + 12'(idx)));
                emit(enc_s(f3_word, 0, 5, 12'h300 + 12'(4 * idx)));
                expect_store(14'h300 + 14'(4 * idx),
                    taken_map[f][p] ? 32'h100 + idx : 32'h200 + idx, 4'hF);
                idx++;
            end
        end
        emit(enc_s(f3_word, 0, 0, 12'hFFC));
        run_program();
        compare_stores("branch");
    endtask

    task automatic test_jumps();
        clear_expected();
        begin_program();
        emit(enc_i(op_alu_imm, f3_add, 1, 0, 12'h040));
        emit(enc_j(5, 21'd12));
        emit(enc_i(op_alu_imm, f3_add, 7, 0, 12'h7BD));
        emit(enc_s(f3_word, 0, 7, 12'h408));
        emit(enc_s(f3_word, 0, 5, 12'h400));
        emit(enc_i(op_jalr, 3'b000, 6, 1, 12'd4));
        emit(enc_s(f3_word, 0, 7, 12'h408));
        wp = 32'h44;
        emit(enc_s(f3_word, 0, 6, 12'h404));
        emit(enc_s(f3_word, 0, 0, 12'hFFC));
        // links are the jump's pc plus four
        expect_store(14'h400, 32'd8, 4'hF);
        expect_store(14'h404, 32'd24, 4'hF);
        run_program();
        compare_stores("jump");
    endtask

    task automatic test_backpressure();
        random_delays = 1'b0;
        test_alu();
        sv_addr = got_addr;
        sv_data = got_data;
        sv_strb = got_strb;
        random_delays = 1'b1;
        begin_program();
        load_alu_program();
        run_program();
        exp_addr = sv_addr;
        exp_data = sv_data;
        exp_strb = sv_strb;
        compare_stores("backpressure");
    endtask

    initial begin
        rstn          = 1'b0;
        inst_delay    = 2'd0;
        data_delay    = 2'd0;
        random_delays = 1'b1;
        rng           = 32'h5034;
        errors        = 0;
        cycles        = 0;
        sentinel_seen = 1'b0;
        wp            = 0;
        test_alu();
        test_load_store();
        test_branches();
        test_jumps();
        test_backpressure();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_mem_model.sv */
`default_nettype none

module tb_mem_model
    import isa_pkg::*;
    import core_pkg::*;
(
    input  wire             clk,
    input  wire             rstn,
    input  wire             inst_req,
    input  wire inst_addr_t inst_addr,
    output logic            inst_ack,
    output word_t           inst_data,
    input  wire             data_req,
    input  wire             data_we,
    input  wire strobe_t    data_strobe,
    input  wire data_addr_t data_addr,
    input  wire word_t      data_wdata,
    output logic            data_ack,
    output word_t           data_rdata,
    input  wire [1:0]       inst_delay,
    input  wire [1:0]       data_delay
);
    timeunit 1ns;
    timeprecision 1ps;

    word_t imem [0:1023];
    word_t dmem [0:4095];
    int    inst_wait;
    int    data_wait;

    // cycles a request has been pending without an ack
    always @(posedge clk) begin
        if (!rstn || !inst_req || inst_ack) begin
            inst_wait <= 0;
        end else begin
            inst_wait <= inst_wait + 1;
        end
        if (!rstn || !data_req || data_ack) begin
            data_wait <= 0;
        end else begin
            data_wait <= data_wait + 1;
        end
    end

    assign inst_ack   = inst_req && (inst_wait >= int'(inst_delay));
    assign data_ack   = data_req && (data_wait >= int'(data_delay));
    assign inst_data  = imem[inst_addr[11:2]];
    assign data_rdata = dmem[data_addr[13:2]];

    // byte-lane write on the store's ack
    always @(posedge clk) begin
        if (rstn && data_req && data_ack && data_we) begin
            for (int i = 0; i < len_strobe; i++) begin
                if (data_strobe[i]) begin
                    dmem[data_addr[13:2]][i*8 +: 8] <= data_wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire
